// File: rtl/video_pkg.sv
`default_nettype none

package video_pkg;

	// dram word address
	typedef logic [20:0] vaddr_t;
	// dram page, tile map, tile gfx and font pages
	typedef logic [7:0] page_t;
	// scan line counter
	typedef logic [8:0] line_t;
	// tile descriptor, tile number in [10:0]
	typedef logic [15:0] tword_t;

	typedef enum logic [1:0] {VMODE_OFF, VMODE_ZX, VMODE_TM} vmode_e;

	// fetch window kind, also the sequencer state
	typedef enum logic [2:0] {FETCH_IDLE, FETCH_TILE, FETCH_XS, FETCH_GFX, FETCH_ZX} fetch_e;

	typedef struct packed {
		vmode_e mode;
		logic   tp1en;
	} vmode_t;

	typedef struct packed {
		logic       scr_page;
		page_t      tp;
		page_t      tgp0;
		page_t      tgp1;
		page_t      fp;
		logic [1:0] fa;
		logic [8:0] xs;
		line_t      ys;
	} vcfg_t;

	// single-cycle strobes plus the vpix level
	typedef struct packed {
		logic int_start;
		logic hsync_start;
		logic line_start;
		logic yctr_init;
		logic vpix;
	} vtime_t;

	// fetches per line
	localparam int ZX_WORDS   = 32;
	localparam int TILE_WORDS = 16;
	localparam int XS_WORDS   = 2;
	localparam int GFX_WORDS  = 64;

endpackage

`default_nettype wire

// File: rtl/video_mode_decode.sv
`timescale 1ns/1ps
`default_nettype none

module video_mode_decode (
	input  wire               clk,
	input  wire               rst_n,
	input  wire [7:0]         mode_reg,
	output video_pkg::vmode_t mode
);
	import video_pkg::*;

	vmode_t mode_d;

	// [1:0] mode select, [2] second tile plane
	always_comb
	begin
		mode_d.tp1en = 1'b0;
		case (mode_reg[1:0])
			2'b01: mode_d.mode = VMODE_ZX;
			2'b10:
			begin
				mode_d.mode  = VMODE_TM;
				// plane 1 only means something in tile mode
				mode_d.tp1en = mode_reg[2];
			end
			// 2'b11 reserved
			default: mode_d.mode = VMODE_OFF;
		endcase
	end

	// mode changes only on a clock edge
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mode.mode  <= VMODE_OFF;
			mode.tp1en <= 1'b0;
		end
		else
			mode <= mode_d;
	end

endmodule

`default_nettype wire

// File: rtl/video_fetch_window.sv
`timescale 1ns/1ps
`default_nettype none

module video_fetch_window (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire video_pkg::vmode_t mode,
	input  wire video_pkg::vtime_t tim,
	input  wire                    video_next,
	output video_pkg::fetch_e      fetch_kind,
	output logic                   video_req
);
	import video_pkg::*;

	fetch_e     state;
	fetch_e     state_nxt;
	// grants taken in the current window
	logic [6:0] cnt;
	logic [6:0] win_len;
	logic       last_grant;

	// window length in grants
	always_comb
	begin
		case (state)
			FETCH_TILE: win_len = mode.tp1en ? 7'(TILE_WORDS) : 7'(TILE_WORDS / 2);
			FETCH_XS:   win_len = 7'(XS_WORDS);
			FETCH_GFX:  win_len = 7'(GFX_WORDS);
			FETCH_ZX:   win_len = 7'(ZX_WORDS);
			default:    win_len = 7'd1;
		endcase
	end

	assign last_grant = video_next && (cnt == win_len - 7'd1);

	always_comb
	begin
		state_nxt = state;
		case (state)
			FETCH_IDLE:
			begin
				// tiles and xs go out during hblank
				if (mode.mode == VMODE_TM && tim.hsync_start)
					state_nxt = tim.vpix ? FETCH_TILE : FETCH_XS;
				else if (tim.line_start && tim.vpix)
				begin
					if (mode.mode == VMODE_TM)
						state_nxt = FETCH_GFX;
					else if (mode.mode == VMODE_ZX)
						state_nxt = FETCH_ZX;
				end
			end
			// xs words always follow the tile descriptors
			FETCH_TILE:
				if (last_grant)
					state_nxt = FETCH_XS;
			default:
				if (last_grant)
					state_nxt = FETCH_IDLE;
		endcase
		// display switched off, drop any open window
		if (mode.mode == VMODE_OFF)
			state_nxt = FETCH_IDLE;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= FETCH_IDLE;
			cnt   <= '0;
		end
		else
		begin
			state <= state_nxt;
			// counter restarts with every new window
			if (state_nxt != state)
				cnt <= '0;
			else if (video_next && state != FETCH_IDLE)
				cnt <= cnt + 7'd1;
		end
	end

	assign fetch_kind = state;
	// request stays up through back-pressure until the last grant
	assign video_req  = (state != FETCH_IDLE);

endmodule

`default_nettype wire

// File: rtl/video_addrgen.sv
`timescale 1ns/1ps
`default_nettype none

module video_addrgen (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire video_pkg::vmode_t mode,
	input  wire video_pkg::vcfg_t  cfg,
	input  wire video_pkg::vtime_t tim,
	input  wire video_pkg::fetch_e fetch_kind,
	input  wire                    video_next,
	input  wire                    video_strobe,
	input  wire video_pkg::tword_t video_data,
	output video_pkg::vaddr_t      video_addr
);
	import video_pkg::*;

	// zx counter
	// [0] attr or pix, [4:1] word column, [12:5] screen line
	logic [12:0] zxctr;
	logic [12:0] zxctr_nxt;
	line_t       yctr;
	line_t       yctr_nxt;
	// column, [0] is the tile plane
	logic [7:0]  xctr;
	logic [7:0]  xctr_nxt;
	// latest tile numbers per plane
	logic [10:0] tn0;
	logic [10:0] tn1;
	logic [10:0] tn0_nxt;
	logic [10:0] tn1_nxt;
	// plane of the outstanding tile fetch
	logic        str_plane;
	fetch_e      kind_q;
	logic        win_start;
	logic        pair_end;
	logic        ld;
	logic        tpn;
	logic [10:0] tnum;
	page_t       tgp;
	logic [5:0]  ty;
	logic [5:0]  tx;
	logic [6:0]  xcnt;
	logic [3:0]  tptr;
	logic [11:0] zx_pix;
	logic [11:0] zx_attr;
	vaddr_t      addr_zx;
	vaddr_t      addr_tile;
	vaddr_t      addr_xs;
	vaddr_t      addr_gfx;
	vaddr_t      addr_sel;

	// first cycle of any window, also tile -> xs
	assign win_start = (fetch_kind != FETCH_IDLE) && (fetch_kind != kind_q);
	// data for the last plane of a tile is in
	assign pair_end  = video_strobe && (str_plane || !mode.tp1en);
	assign ld        = win_start || video_next || pair_end;

	// counter next values, the address is formed from these
	always_comb
	begin
		zxctr_nxt = zxctr;
		if (tim.int_start)
			zxctr_nxt = '0;
		else if (video_next && fetch_kind == FETCH_ZX)
			zxctr_nxt = zxctr + 13'd1;

		yctr_nxt = yctr;
		if (tim.hsync_start)
			yctr_nxt = tim.yctr_init ? '0 : yctr + 9'd1;

		// one plane skips the plane bit
		xctr_nxt = xctr;
		if (win_start)
			xctr_nxt = '0;
		else if (video_next)
			xctr_nxt = xctr + (mode.tp1en ? 8'd1 : 8'd2);

		tn0_nxt = tn0;
		tn1_nxt = tn1;
		if (video_strobe)
		begin
			if (str_plane)
				tn1_nxt = video_data[10:0];
			else
				tn0_nxt = video_data[10:0];
		end
	end

	assign tpn  = xctr_nxt[0];
	assign tnum = tpn ? tn1_nxt : tn0_nxt;
	// tile number [10:9] selects a page above the gfx page
	assign tgp  = (tpn ? cfg.tgp1 : cfg.tgp0) + page_t'(tnum[10:9]);
	assign ty   = cfg.ys[8:3] + yctr_nxt[8:3];
	// low tile x bits from the column, high ones from the line
	assign tx   = {yctr_nxt[2:0], xctr_nxt[3:1]};
	// xs[1:0] is the pixel offset, left to the shifter
	assign xcnt = xctr_nxt[7:1] + cfg.xs[8:2];
	assign tptr = {yctr_nxt[2:0], xcnt[0]};

	// standard zx layout, thirds of the screen interleaved
	assign zx_pix  = {zxctr_nxt[12:11], zxctr_nxt[7:5], zxctr_nxt[10:8], zxctr_nxt[4:1]};
	assign zx_attr = {3'b110, zxctr_nxt[12:8], zxctr_nxt[4:1]};

	assign addr_zx   = {6'b000001, cfg.scr_page, 2'b10, zxctr_nxt[0] ? zx_attr : zx_pix};
	// 8.6.6.1
	assign addr_tile = {cfg.tp, ty, tx, tpn};
	// 8.2.1.1.9
	assign addr_xs   = {cfg.fp, cfg.fa, 1'b0, tpn, yctr_nxt};
	// 8.9.4
	assign addr_gfx  = {tgp, tnum[8:0], tptr};

	always_comb
	begin
		case (fetch_kind)
			FETCH_ZX:   addr_sel = addr_zx;
			FETCH_TILE: addr_sel = addr_tile;
			FETCH_XS:   addr_sel = addr_xs;
			FETCH_GFX:  addr_sel = addr_gfx;
			default:    addr_sel = video_addr;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			zxctr      <= '0;
			yctr       <= '0;
			xctr       <= '0;
			str_plane  <= 1'b0;
			kind_q     <= FETCH_IDLE;
			video_addr <= '0;
		end
		else
		begin
			zxctr  <= zxctr_nxt;
			yctr   <= yctr_nxt;
			xctr   <= xctr_nxt;
			kind_q <= fetch_kind;
			// plane of the address the arbiter just took
			if (video_next && fetch_kind == FETCH_TILE)
				str_plane <= xctr[0];
			// holds through back-pressure
			if (ld)
				video_addr <= addr_sel;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tn0 <= '0;
			tn1 <= '0;
		end
		else
		begin
			tn0 <= tn0_nxt;
			tn1 <= tn1_nxt;
		end
	end

endmodule

`default_nettype wire

// File: rtl/video_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_fetch_top (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire [7:0]               mode_reg,
	input  wire video_pkg::vcfg_t   cfg,
	input  wire video_pkg::vtime_t  tim,
	input  wire                     video_next,
	input  wire                     video_strobe,
	input  wire video_pkg::tword_t  video_data,
	output wire video_pkg::vaddr_t  video_addr,
	output wire                     video_req,
	output wire video_pkg::fetch_e  fetch_kind
);
	import video_pkg::*;

	// registered mode, shared by window and addrgen
	wire vmode_t mode;

	video_mode_decode u_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.mode_reg (mode_reg),
		.mode     (mode)
	);

	video_fetch_window u_window (
		.clk        (clk),
		.rst_n      (rst_n),
		.mode       (mode),
		.tim        (tim),
		.video_next (video_next),
		.fetch_kind (fetch_kind),
		.video_req  (video_req)
	);

	video_addrgen u_addrgen (
		.clk          (clk),
		.rst_n        (rst_n),
		.mode         (mode),
		.cfg          (cfg),
		.tim          (tim),
		.fetch_kind   (fetch_kind),
		.video_next   (video_next),
		.video_strobe (video_strobe),
		.video_data   (video_data),
		.video_addr   (video_addr)
	);

endmodule

`default_nettype wire

// File: sim/tb_video_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_fetch;
	import video_pkg::*;

	// one scenario of the table
	typedef struct packed {
		logic [7:0] mode_reg;
		vcfg_t      cfg;
		logic [3:0] lines;
		logic [7:0] vpix;
		logic [3:0] gap;
	} row_t;

	// clock cycles allowed per scan line
	localparam int LINE_BUDGET = 3000;

	logic        clk;
	logic        rst_n;
	logic [7:0]  mode_reg;
	vcfg_t       cfg;
	vtime_t      tim;
	logic        video_next;
	logic        video_strobe;
	tword_t      video_data;
	vaddr_t      video_addr;
	logic        video_req;
	fetch_e      fetch_kind;

	row_t        rows [8];
	string       row_name [8];
	int          n_rows;
	int          total_lines;
	int          errors;
	int          checks;
	logic [31:0] rng;
	string       cur_name;
	// reference model state
	vcfg_t       ccfg;
	logic        ctm;
	logic        czx;
	logic        ctwo;
	int          cgap;
	line_t       ym;
	logic [12:0] zxm;
	logic [10:0] tn0m;
	logic [10:0] tn1m;
	// tile word owed to the dut next cycle
	logic        st_pend;
	tword_t      data_pend;

	video_fetch_top dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.mode_reg     (mode_reg),
		.cfg          (cfg),
		.tim          (tim),
		.video_next   (video_next),
		.video_strobe (video_strobe),
		.video_data   (video_data),
		.video_addr   (video_addr),
		.video_req    (video_req),
		.fetch_kind   (fetch_kind)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// zx screen page, byte address halved to a word
	function automatic int zx_word(input logic [12:0] z);
		int y;
		int col;
		y   = int'(z[12:5]);
		col = int'(z[4:1]);
		// attributes sit after the 6144 pixel bytes
		if (z[0])
			return (6144 + (y / 8) * 32 + col * 2) / 2;
		return ((y / 64) * 2048 + (y % 8) * 256 + ((y / 8) % 8) * 32 + col * 2) / 2;
	endfunction

	// address of grant k in a window of this kind
	function automatic vaddr_t expect_addr(input fetch_e kind, input int k);
		int plane;
		int half;
		int tn;
		int y;
		int a;
		// single plane: plane bit stays 0, column advances every grant
		plane = ctwo ? k % 2 : 0;
		half  = ctwo ? k / 2 : k;
		y     = int'(ym);
		case (kind)
			FETCH_ZX:
				a = 32768 + int'(ccfg.scr_page) * 16384 + 8192 + zx_word(zxm + 13'(k));
			FETCH_TILE:
				a = int'(ccfg.tp) * 8192 + ((int'(ccfg.ys) / 8 + y / 8) % 64) * 128
					+ ((y % 8) * 8 + half) * 2 + plane;
			FETCH_XS:
				a = int'(ccfg.fp) * 8192 + int'(ccfg.fa) * 2048 + plane * 512 + y;
			FETCH_GFX:
			begin
				tn = (plane == 1) ? int'(tn1m) : int'(tn0m);
				a  = ((int'((plane == 1) ? ccfg.tgp1 : ccfg.tgp0) + tn / 512) % 256) * 8192
					+ (tn % 512) * 16 + (y % 8) * 2 + (half + int'(ccfg.xs) / 4) % 2;
			end
			default: a = 0;
		endcase
		return vaddr_t'(a);
	endfunction

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", cur_name, what, exp, act);
		end
	endtask

	// drive on the rising edge, look at the dut on the falling one
	task automatic step(input logic nx, input vtime_t t);
		@(posedge clk);
		video_next   <= nx;
		video_strobe <= st_pend;
		video_data   <= data_pend;
		tim          <= t;
		st_pend = 1'b0;
		@(negedge clk);
	endtask

	task automatic expect_idle(input string what);
		check({what, " video_req"}, 32'd0, 32'(video_req));
		check({what, " fetch_kind"}, 32'(FETCH_IDLE), 32'(fetch_kind));
	endtask

	// entered in the first cycle of the window
	task automatic run_window(input fetch_e kind, input int len, input vtime_t t);
		int   k;
		logic nx;
		k = 0;
		check("window open", 32'(kind), 32'(fetch_kind));
		while (k < len)
		begin
			rng = xorshift(rng);
			nx  = (int'(rng[7:0]) % cgap) == 0;
			step(nx, t);
			// address must hold between grants too
			check($sformatf("%s addr %0d", kind.name(), k),
				32'(expect_addr(kind, k)), 32'(video_addr));
			check("fetch_kind", 32'(kind), 32'(fetch_kind));
			check("video_req", 32'd1, 32'(video_req));
			if (nx)
			begin
				if (kind == FETCH_TILE)
				begin
					rng       = xorshift(rng);
					st_pend   = 1'b1;
					data_pend = rng[15:0];
					if (ctwo && (k % 2 == 1))
						tn1m = rng[10:0];
					else
						tn0m = rng[10:0];
				end
				k++;
			end
		end
		if (kind == FETCH_ZX)
			zxm = zxm + 13'(len);
	endtask

	task automatic play_line(input int ln, input logic vp);
		vtime_t idle_t;
		vtime_t t;
		idle_t        = '0;
		idle_t.vpix   = vp;
		t             = idle_t;
		t.hsync_start = 1'b1;
		// first line of the frame restarts the line counter
		t.yctr_init   = (ln == 0);
		step(1'b0, t);
		ym = (ln == 0) ? '0 : ym + 9'd1;
		step(1'b0, idle_t);
		// hblank: descriptors then scroll words
		if (ctm)
		begin
			if (vp)
			begin
				run_window(FETCH_TILE, ctwo ? TILE_WORDS : TILE_WORDS / 2, idle_t);
				step(1'b0, idle_t);
			end
			run_window(FETCH_XS, XS_WORDS, idle_t);
		end
		step(1'b0, idle_t);
		expect_idle("hblank end");
		t            = idle_t;
		t.line_start = 1'b1;
		step(1'b0, t);
		step(1'b0, idle_t);
		if (vp && (ctm || czx))
		begin
			run_window(ctm ? FETCH_GFX : FETCH_ZX, ctm ? GFX_WORDS : ZX_WORDS, idle_t);
			step(1'b0, idle_t);
		end
		expect_idle("line end");
	endtask

	task automatic play_row(input int r);
		vtime_t t;
		int     ln;
		cur_name = row_name[r];
		ccfg     = rows[r].cfg;
		cgap     = int'(rows[r].gap);
		// mode bits 01 zx, 10 tile, [2] second plane
		czx      = rows[r].mode_reg[1:0] == 2'b01;
		ctm      = rows[r].mode_reg[1:0] == 2'b10;
		ctwo     = ctm && rows[r].mode_reg[2];
		@(posedge clk);
		mode_reg <= rows[r].mode_reg;
		cfg      <= rows[r].cfg;
		@(negedge clk);
		// decoded mode lands a cycle later
		step(1'b0, '0);
		t           = '0;
		t.int_start = 1'b1;
		step(1'b0, t);
		zxm = '0;
		for (ln = 0; ln < int'(rows[r].lines); ln++)
			play_line(ln, rows[r].vpix[ln]);
	endtask

	task automatic add_row(input string name, input logic [7:0] mr, input vcfg_t c,
		input int lines, input logic [7:0] vp, input int gap);
		row_name[n_rows]      = name;
		rows[n_rows].mode_reg = mr;
		rows[n_rows].cfg      = c;
		rows[n_rows].lines    = 4'(lines);
		rows[n_rows].vpix     = vp;
		rows[n_rows].gap      = 4'(gap);
		total_lines += lines;
		n_rows++;
	endtask

	task automatic load_table();
		// name, mode_reg, cfg {scr_page, tp, tgp0, tgp1, fp, fa, xs, ys}, lines, vpix, grant gap
		add_row("zx_page0", 8'h01,
			vcfg_t'{1'b0, 8'h00, 8'h00, 8'h00, 8'h00, 2'd0, 9'h000, 9'h000}, 3, 8'h07, 2);
		add_row("zx_page1_burst", 8'h05,
			vcfg_t'{1'b1, 8'h11, 8'h22, 8'h33, 8'h44, 2'd1, 9'h055, 9'h066}, 2, 8'h03, 1);
		add_row("tm_two_planes", 8'h06,
			vcfg_t'{1'b0, 8'h12, 8'h40, 8'h80, 8'h3c, 2'd2, 9'h0d5, 9'h013}, 3, 8'h07, 2);
		add_row("tm_one_plane", 8'h02,
			vcfg_t'{1'b0, 8'ha5, 8'h20, 8'hc0, 8'h7e, 2'd1, 9'h1f8, 9'h0f7}, 3, 8'h07, 1);
		add_row("tm_backpressure", 8'h06,
			vcfg_t'{1'b0, 8'h12, 8'h40, 8'h80, 8'h3c, 2'd2, 9'h0d5, 9'h013}, 2, 8'h03, 7);
		// tgp0 near the top wraps the page sum
		add_row("tm_blanking", 8'h06,
			vcfg_t'{1'b1, 8'h5a, 8'hfe, 8'h01, 8'h33, 2'd3, 9'h003, 9'h1c8}, 4, 8'h06, 2);
		add_row("off_mode", 8'h00,
			vcfg_t'{1'b0, 8'h12, 8'h40, 8'h80, 8'h3c, 2'd2, 9'h0d5, 9'h013}, 2, 8'h03, 1);
		add_row("off_reserved", 8'h07,
			vcfg_t'{1'b1, 8'h12, 8'h40, 8'h80, 8'h3c, 2'd2, 9'h0d5, 9'h013}, 2, 8'h03, 1);
	endtask

	// bounded by the total line count of the table
	initial
	begin
		wait (total_lines > 0);
		repeat (total_lines * LINE_BUDGET + n_rows * 16 + 16) @(posedge clk);
		$display("watchdog: run did not finish in time, DUT or testbench is hung");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		rst_n        <= 1'b0;
		mode_reg     <= '0;
		cfg          <= '0;
		tim          <= '0;
		video_next   <= 1'b0;
		video_strobe <= 1'b0;
		video_data   <= '0;
		st_pend      = 1'b0;
		data_pend    = '0;
		rng          = 32'd86403;
		errors       = 0;
		checks       = 0;
		n_rows       = 0;
		total_lines  = 0;
		load_table();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		cur_name = "reset";
		expect_idle("after reset");
		check("video_addr", 32'd0, 32'(video_addr));
		for (int r = 0; r < n_rows; r++)
			play_row(r);
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
rtl/video_pkg.sv
rtl/video_mode_decode.sv
rtl/video_fetch_window.sv
rtl/video_addrgen.sv
rtl/video_fetch_top.sv
sim/tb_video_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module tb_video_fetch -f sources.f -o tb_video_fetch

out="$(./obj_dir/tb_video_fetch)"
echo "$out"
if grep -qx "TEST RESULT: PASS" <<< "$out"; then
	exit 0
fi
exit 1
